/* common/axil_pkg.sv */
// AXI-lite memory subsystem types for opcodes, responses and FSM states
package axil_pkg;

  // ----------------------------------------
  // Host command opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } axil_op_e;

  // Response codes used on the B and R channels
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // ----------------------------------------
  // SRAM wrapper read channel
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } rd_state_e;

  // SRAM wrapper write channel
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

  // Master sequencing, one transaction at a time
  typedef enum logic [2:0] {
    M_IDLE = 3'd0,
    M_AR   = 3'd1,
    M_R    = 3'd2,
    M_AW   = 3'd3,
    M_W    = 3'd4,
    M_B    = 3'd5
  } mst_state_e;

endpackage

/* verilog/cmd_fifo.sv */
// Command FIFO that buffers host command strobes and flags dropped pushes
`timescale 1ns/10ps

module cmd_fifo import axil_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  input  logic                  i_push,
  input  axil_op_e              i_op,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic [STRB_WIDTH-1:0] i_wstrb,
  input  logic                  i_pop,
  output logic                  o_empty,
  output axil_op_e              o_op,
  output logic [ADDR_WIDTH-1:0] o_addr,
  output logic [DATA_WIDTH-1:0] o_wdata,
  output logic [STRB_WIDTH-1:0] o_wstrb,
  output logic                  o_overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  axil_op_e              op_mem    [FIFO_DEPTH];
  logic [ADDR_WIDTH-1:0] addr_mem  [FIFO_DEPTH];
  logic [DATA_WIDTH-1:0] wdata_mem [FIFO_DEPTH];
  logic [STRB_WIDTH-1:0] wstrb_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  // Full FIFO drops the push even if a pop happens in the same cycle
  assign do_push = i_push && !full;
  assign do_pop  = i_pop && !o_empty;

  // ----------------------------------------
  // Entry storage
  always_ff @(posedge i_aclk) begin
    if (do_push) begin
      op_mem[wr_ptr]    <= i_op;
      addr_mem[wr_ptr]  <= i_addr;
      wdata_mem[wr_ptr] <= i_wdata;
      wstrb_mem[wr_ptr] <= i_wstrb;
    end
  end

  // Pointers wrap at the depth, count tracks occupancy
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      o_overflow <= 1'b0;
    end else if (i_push && full) begin
      o_overflow <= 1'b1;
    end
  end

  // Head of queue
  assign o_op    = op_mem[rd_ptr];
  assign o_addr  = addr_mem[rd_ptr];
  assign o_wdata = wdata_mem[rd_ptr];
  assign o_wstrb = wstrb_mem[rd_ptr];

endmodule

/* axil_master/axil_master.sv */
// AXI-lite master that pops queued commands and runs one bus transaction each
`timescale 1ns/10ps

module axil_master import axil_pkg::*; #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  // Command FIFO head
  input  logic                  i_empty,
  input  axil_op_e              i_op,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic [STRB_WIDTH-1:0] i_wstrb,
  output logic                  o_pop,
  // Write address channel
  output logic                  o_awvalid,
  input  logic                  i_awready,
  output logic [ADDR_WIDTH-1:0] o_awaddr,
  // Write data channel
  output logic                  o_wvalid,
  input  logic                  i_wready,
  output logic [DATA_WIDTH-1:0] o_wdata,
  output logic [STRB_WIDTH-1:0] o_wstrb,
  // Write response channel
  input  logic                  i_bvalid,
  output logic                  o_bready,
  input  axil_resp_e            i_bresp,
  // Read address channel
  output logic                  o_arvalid,
  input  logic                  i_arready,
  output logic [ADDR_WIDTH-1:0] o_araddr,
  // Read data channel
  input  logic                  i_rvalid,
  output logic                  o_rready,
  input  logic [DATA_WIDTH-1:0] i_rdata,
  input  axil_resp_e            i_rresp,
  // Host response
  output logic                  o_rsp_valid,
  output axil_op_e              o_rsp_op,
  output logic [DATA_WIDTH-1:0] o_rsp_rdata,
  output logic                  o_rsp_err
);

  mst_state_e            state;
  axil_op_e              cmd_op;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_WIDTH-1:0] cmd_wdata;
  logic [STRB_WIDTH-1:0] cmd_wstrb;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  ar_fire;
  logic                  r_fire;

  assign aw_fire = o_awvalid && i_awready;
  assign w_fire  = o_wvalid  && i_wready;
  assign b_fire  = i_bvalid  && o_bready;
  assign ar_fire = o_arvalid && i_arready;
  assign r_fire  = i_rvalid  && o_rready;

  // ----------------------------------------
  // Sequencer; pop goes out one cycle after a non-empty FIFO is seen
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state <= M_IDLE;
      o_pop <= 1'b0;
    end else begin
      o_pop <= 1'b0;
      case (state)
        M_IDLE: begin
          if (o_pop) begin
            state <= (i_op == OP_READ) ? M_AR : M_AW;
          end else if (!i_empty) begin
            o_pop <= 1'b1;
          end
        end
        M_AR:    if (ar_fire) state <= M_R;
        M_R:     if (r_fire)  state <= M_IDLE;
        M_AW:    if (aw_fire) state <= M_W;
        M_W:     if (w_fire)  state <= M_B;
        M_B:     if (b_fire)  state <= M_IDLE;
        default: state <= M_IDLE;
      endcase
    end
  end

  // Head fields captured while pop is high
  always_ff @(posedge i_aclk) begin
    if (o_pop) begin
      cmd_op    <= i_op;
      cmd_addr  <= i_addr;
      cmd_wdata <= i_wdata;
      cmd_wstrb <= i_wstrb;
    end
  end

  // ----------------------------------------
  // Response strobe follows the R or B transfer
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= r_fire || b_fire;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      o_rsp_op    <= cmd_op;
      o_rsp_rdata <= i_rdata;
      o_rsp_err   <= (i_rresp == RESP_SLVERR);
    end else if (b_fire) begin
      o_rsp_op    <= cmd_op;
      o_rsp_rdata <= '0;
      o_rsp_err   <= (i_bresp == RESP_SLVERR);
    end
  end

  // Channel drive straight from state, payload held in command registers
  assign o_arvalid = (state == M_AR);
  assign o_araddr  = cmd_addr;
  assign o_rready  = (state == M_R);
  assign o_awvalid = (state == M_AW);
  assign o_awaddr  = cmd_addr;
  assign o_wvalid  = (state == M_W);
  assign o_wdata   = cmd_wdata;
  assign o_wstrb   = cmd_wstrb;
  assign o_bready  = (state == M_B);

endmodule

/* axil_sram/axil_sram_wrap.sv */
// AXI-lite slave over a byte-strobed SRAM array with range checking
`timescale 1ns/10ps

module axil_sram_wrap import axil_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_DEPTH  = 64,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  // Write address channel
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [ADDR_WIDTH-1:0] i_awaddr,
  // Protection bits are accepted and ignored
  input  logic [2:0]            i_awprot,
  // Write data channel
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic [STRB_WIDTH-1:0] i_wstrb,
  // Write response channel
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output axil_resp_e            o_bresp,
  // Read address channel
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  logic [ADDR_WIDTH-1:0] i_araddr,
  input  logic [2:0]            i_arprot,
  // Read data channel
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [DATA_WIDTH-1:0] o_rdata,
  output axil_resp_e            o_rresp
);

  localparam int ADDR_LSB = $clog2(STRB_WIDTH);
  localparam int IDX_W    = ADDR_WIDTH - ADDR_LSB;
  localparam int MEM_AW   = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
  rd_state_e             rd_state;
  wr_state_e             wr_state;
  logic [IDX_W-1:0]      rd_idx;
  logic [IDX_W-1:0]      wr_idx;
  logic                  rd_hit;
  logic                  wr_hit;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  ar_fire;
  logic                  r_fire;

  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid  && o_wready;
  assign b_fire  = o_bvalid  && i_bready;
  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid  && i_rready;

  // Word index, low byte-lane bits dropped
  assign rd_idx = i_araddr[ADDR_WIDTH-1:ADDR_LSB];
  assign rd_hit = (rd_idx < MEM_DEPTH);
  assign wr_hit = (wr_idx < MEM_DEPTH);

  // ----------------------------------------
  // Read channel
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_DATA;
        RD_DATA: if (r_fire)  rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Out-of-range reads return zero
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      o_rdata <= rd_hit ? mem[rd_idx[MEM_AW-1:0]] : '0;
      o_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ----------------------------------------
  // Write channel
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (aw_fire) wr_state <= WR_DATA;
        WR_DATA: if (w_fire)  wr_state <= WR_RESP;
        WR_RESP: if (b_fire)  wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Address latched on AW, response decided on W
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_idx <= i_awaddr[ADDR_WIDTH-1:ADDR_LSB];
    end
    if (w_fire) begin
      o_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Byte lanes written only where the strobe is set
  always_ff @(posedge i_aclk) begin
    if (w_fire && wr_hit) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx[MEM_AW-1:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign o_arready = (rd_state == RD_IDLE);
  assign o_rvalid  = (rd_state == RD_DATA);
  assign o_awready = (wr_state == WR_IDLE);
  assign o_wready  = (wr_state == WR_DATA);
  assign o_bvalid  = (wr_state == WR_RESP);

endmodule

/* verilog/axil_sram_sys.sv */
// Memory subsystem top joining the command FIFO, AXI-lite master and SRAM slave
`timescale 1ns/10ps

module axil_sram_sys import axil_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_DEPTH  = 64,
  parameter int FIFO_DEPTH = 4,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  // Host command strobe, no back-pressure
  input  logic                  i_cmd_valid,
  input  axil_op_e              i_cmd_op,
  input  logic [ADDR_WIDTH-1:0] i_cmd_addr,
  input  logic [DATA_WIDTH-1:0] i_cmd_wdata,
  input  logic [STRB_WIDTH-1:0] i_cmd_wstrb,
  // Host response strobe
  output logic                  o_rsp_valid,
  output axil_op_e              o_rsp_op,
  output logic [DATA_WIDTH-1:0] o_rsp_rdata,
  output logic                  o_rsp_err,
  output logic                  o_overflow
);

  // FIFO head to master
  logic                  fifo_empty;
  logic                  fifo_pop;
  axil_op_e              head_op;
  logic [ADDR_WIDTH-1:0] head_addr;
  logic [DATA_WIDTH-1:0] head_wdata;
  logic [STRB_WIDTH-1:0] head_wstrb;

  // ----------------------------------------
  // AXI-lite channels between master and SRAM
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  bvalid;
  logic                  bready;
  axil_resp_e            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [DATA_WIDTH-1:0] rdata;
  axil_resp_e            rresp;

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_fifo (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_push     (i_cmd_valid),
    .i_op       (i_cmd_op),
    .i_addr     (i_cmd_addr),
    .i_wdata    (i_cmd_wdata),
    .i_wstrb    (i_cmd_wstrb),
    .i_pop      (fifo_pop),
    .o_empty    (fifo_empty),
    .o_op       (head_op),
    .o_addr     (head_addr),
    .o_wdata    (head_wdata),
    .o_wstrb    (head_wstrb),
    .o_overflow (o_overflow)
  );

  axil_master #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_master (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_empty     (fifo_empty),
    .i_op        (head_op),
    .i_addr      (head_addr),
    .i_wdata     (head_wdata),
    .i_wstrb     (head_wstrb),
    .o_pop       (fifo_pop),
    .o_awvalid   (awvalid),
    .i_awready   (awready),
    .o_awaddr    (awaddr),
    .o_wvalid    (wvalid),
    .i_wready    (wready),
    .o_wdata     (wdata),
    .o_wstrb     (wstrb),
    .i_bvalid    (bvalid),
    .o_bready    (bready),
    .i_bresp     (bresp),
    .o_arvalid   (arvalid),
    .i_arready   (arready),
    .o_araddr    (araddr),
    .i_rvalid    (rvalid),
    .o_rready    (rready),
    .i_rdata     (rdata),
    .i_rresp     (rresp),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_op    (o_rsp_op),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err)
  );

  // Protection bits tied off
  axil_sram_wrap #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_awprot  (3'b000),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .i_arprot  (3'b000),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

endmodule

/* testbench/axil_sram_assert.sv */
// AXI-lite protocol checks on the SRAM wrapper ports, attached by bind
`timescale 1ns/10ps

module axil_sram_assert import axil_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input logic                  i_aclk,
  input logic                  i_rst_n,
  input logic                  i_awvalid,
  input logic                  i_awready,
  input logic [ADDR_WIDTH-1:0] i_awaddr,
  input logic                  i_wvalid,
  input logic                  i_wready,
  input logic [DATA_WIDTH-1:0] i_wdata,
  input logic [STRB_WIDTH-1:0] i_wstrb,
  input logic                  i_bvalid,
  input logic                  i_bready,
  input axil_resp_e            i_bresp,
  input logic                  i_arvalid,
  input logic                  i_arready,
  input logic [ADDR_WIDTH-1:0] i_araddr,
  input logic                  i_rvalid,
  input logic                  i_rready,
  input logic [DATA_WIDTH-1:0] i_rdata,
  input axil_resp_e            i_rresp,
  input rd_state_e             i_rd_state,
  input wr_state_e             i_wr_state
);

  int fail_cnt = 0;

  // ----------------------------------------
  // Valid held with stable payload until the handshake
  aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
      $error("AW valid dropped or address changed before handshake");
      fail_cnt++;
    end

  w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else begin
      $error("W valid dropped or data changed before handshake");
      fail_cnt++;
    end

  b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else begin
      $error("B valid dropped or response changed before handshake");
      fail_cnt++;
    end

  ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      $error("AR valid dropped or address changed before handshake");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else begin
      $error("R valid dropped or data changed before handshake");
      fail_cnt++;
    end

  // All channels quiet coming out of a reset cycle
  rst_quiet: assert property (@(posedge i_aclk)
    !i_rst_n |=> !i_awvalid && !i_wvalid && !i_bvalid && !i_arvalid && !i_rvalid)
    else begin
      $error("Valid signal high after a reset cycle");
      fail_cnt++;
    end

  // ----------------------------------------
  // No new read address taken while data is pending
  rd_excl: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_rvalid && i_arready))
    else begin
      $error("rvalid and arready high together");
      fail_cnt++;
    end

  // New address only while the slave FSM is idle, one transaction at a time
  ar_single: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid |-> i_rd_state == RD_IDLE)
    else begin
      $error("Read address offered while a read was still in progress");
      fail_cnt++;
    end

  aw_single: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid |-> i_wr_state == WR_IDLE)
    else begin
      $error("Write address offered while a write was still in progress");
      fail_cnt++;
    end

endmodule

bind axil_sram_wrap axil_sram_assert #(
  .DATA_WIDTH (DATA_WIDTH),
  .ADDR_WIDTH (ADDR_WIDTH)
) u_assert (
  .i_aclk     (i_aclk),
  .i_rst_n    (i_rst_n),
  .i_awvalid  (i_awvalid),
  .i_awready  (o_awready),
  .i_awaddr   (i_awaddr),
  .i_wvalid   (i_wvalid),
  .i_wready   (o_wready),
  .i_wdata    (i_wdata),
  .i_wstrb    (i_wstrb),
  .i_bvalid   (o_bvalid),
  .i_bready   (i_bready),
  .i_bresp    (o_bresp),
  .i_arvalid  (i_arvalid),
  .i_arready  (o_arready),
  .i_araddr   (i_araddr),
  .i_rvalid   (o_rvalid),
  .i_rready   (i_rready),
  .i_rdata    (o_rdata),
  .i_rresp    (o_rresp),
  .i_rd_state (rd_state),
  .i_wr_state (wr_state)
);

/* testbench/tb_axil_sram_sys.sv */
// Testbench for the AXI-lite SRAM subsystem with a reference memory model
`timescale 1ns/10ps

module tb_axil_sram_sys import axil_pkg::*; ();

  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 16;
  localparam int MEM_DEPTH    = 64;
  localparam int FIFO_DEPTH   = 4;
  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int RESET_CYCLES = 16;
  localparam int N_PAIRS      = 8;
  localparam int N_BURSTS     = 12;
  localparam int OVF_MAX      = FIFO_DEPTH + 6;
  // Fill, write/read pairs, range test, random bursts, overflow burst
  localparam int NUM_CMDS    = MEM_DEPTH + 4 * N_PAIRS + 6 + N_BURSTS * FIFO_DEPTH + OVF_MAX;
  localparam int DRAIN_LIMIT = 40 * (FIFO_DEPTH + 2);

  logic                  aclk;
  logic                  rst_n;
  logic                  cmd_valid;
  axil_op_e              cmd_op;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_WIDTH-1:0] cmd_wdata;
  logic [STRB_WIDTH-1:0] cmd_wstrb;
  logic                  rsp_valid;
  axil_op_e              rsp_op;
  logic [DATA_WIDTH-1:0] rsp_rdata;
  logic                  rsp_err;
  logic                  overflow;

  // Reference memory and expected responses in issue order
  logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH];
  axil_op_e              exp_op_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  logic                  exp_err_q [$];
  logic [31:0]           rng_state;
  int                    err_cnt;
  int                    chk_cnt;
  int                    drop_cnt;
  bit                    allow_drop;

  axil_sram_sys #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .i_aclk      (aclk),
    .i_rst_n     (rst_n),
    .i_cmd_valid (cmd_valid),
    .i_cmd_op    (cmd_op),
    .i_cmd_addr  (cmd_addr),
    .i_cmd_wdata (cmd_wdata),
    .i_cmd_wstrb (cmd_wstrb),
    .o_rsp_valid (rsp_valid),
    .o_rsp_op    (rsp_op),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_err   (rsp_err),
    .o_overflow  (overflow)
  );

  always #4 aclk = ~aclk;

  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] word_addr(input int idx);
    return ADDR_WIDTH'(idx * STRB_WIDTH);
  endfunction

  // Every bit of the address shows up in the fill word
  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return {addr, ~addr} ^ 32'h3c5a_0f96;
  endfunction

  // Word index from the byte address; out of range means SLVERR
  function automatic void ref_access(input axil_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [DATA_WIDTH-1:0] wdata,
                                     input logic [STRB_WIDTH-1:0] wstrb);
    int idx;
    bit hit;
    idx = int'(addr) / STRB_WIDTH;
    hit = (idx < MEM_DEPTH);
    if (op == OP_WRITE && hit) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wstrb[b]) begin
          ref_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    exp_op_q.push_back(op);
    exp_data_q.push_back((op == OP_READ && hit) ? ref_mem[idx] : '0);
    exp_err_q.push_back(!hit);
  endfunction

  // ----------------------------------------
  // Called at the stimulus point; returns one cycle later at the next one
  task automatic issue_cmd(input axil_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] wdata,
                           input logic [STRB_WIDTH-1:0] wstrb);
    logic ovf_before;
    ovf_before = overflow;
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_addr   = addr;
    cmd_wdata  = wdata;
    cmd_wstrb  = wstrb;
    @(posedge aclk);
    #1;
    cmd_valid = 1'b0;
    // A fresh overflow means this strobe was dropped
    if (overflow && !ovf_before) begin
      drop_cnt++;
      assert (allow_drop) else begin
        $display("Command dropped by the FIFO outside the overflow test");
        err_cnt++;
      end
    end else begin
      ref_access(op, addr, wdata, wstrb);
    end
  endtask

  task automatic issue_rand(input int max_idx);
    logic [31:0] r;
    int idx;
    r   = next_rand();
    idx = int'(r[23:8]) % max_idx;
    issue_cmd(axil_op_e'(r[0]), word_addr(idx), next_rand(), r[4 +: STRB_WIDTH]);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_op_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    if (exp_op_q.size() != 0) begin
      $display("Timed out waiting for %0d outstanding responses", exp_op_q.size());
      err_cnt++;
    end
    @(posedge aclk);
    #1;
  endtask

  // ----------------------------------------
  // Response checker, sampled away from the active edge
  always @(negedge aclk) begin
    axil_op_e              e_op;
    logic [DATA_WIDTH-1:0] e_data;
    logic                  e_err;
    if (rst_n && rsp_valid) begin
      if (exp_op_q.size() == 0) begin
        $display("Response strobe with no command outstanding");
        err_cnt++;
      end else begin
        e_op   = exp_op_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_err  = exp_err_q.pop_front();
        chk_cnt++;
        assert (rsp_op === e_op) else begin
          $display("[ERROR] o_rsp_op: got 0x%0h, expected 0x%0h", rsp_op, e_op);
          err_cnt++;
        end
        assert (rsp_err === e_err) else begin
          $display("[ERROR] o_rsp_err: got 0x%0h, expected 0x%0h", rsp_err, e_err);
          err_cnt++;
        end
        if (e_op == OP_READ) begin
          assert (rsp_rdata === e_data) else begin
            $display("[ERROR] o_rsp_rdata: got 0x%08h, expected 0x%08h", rsp_rdata, e_data);
            err_cnt++;
          end
        end
      end
    end
  end

  initial begin
    repeat (NUM_CMDS * 40 + RESET_CYCLES) @(posedge aclk);
    $display("Watchdog expired with %0d responses outstanding", exp_op_q.size());
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  initial begin
    aclk       = 1'b0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = OP_READ;
    cmd_addr   = '0;
    cmd_wdata  = '0;
    cmd_wstrb  = '0;
    rng_state  = 32'hd099;
    err_cnt    = 0;
    chk_cnt    = 0;
    drop_cnt   = 0;
    allow_drop = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    rst_n = 1'b1;

    // Idle after reset, nothing may come out
    repeat (20) begin
      @(negedge aclk);
      chk_cnt++;
      assert (!rsp_valid && !overflow) else begin
        $display("Response or overflow raised with no command issued");
        err_cnt++;
      end
    end
    @(posedge aclk);
    #1;

    // Known contents everywhere before any read
    for (int i = 0; i < MEM_DEPTH; i++) begin
      issue_cmd(OP_WRITE, word_addr(i), fill_word(word_addr(i)), '1);
      if ((i + 1) % FIFO_DEPTH == 0) begin
        wait_drain();
      end
    end
    wait_drain();

    // Full-strobe write then read back
    for (int i = 0; i < N_PAIRS; i++) begin
      int idx;
      idx = int'(next_rand() % MEM_DEPTH);
      issue_cmd(OP_WRITE, word_addr(idx), next_rand(), '1);
      issue_cmd(OP_READ, word_addr(idx), '0, '0);
      wait_drain();
    end

    // Partial strobes 1 to 8, never all lanes
    for (int i = 0; i < N_PAIRS; i++) begin
      int idx;
      idx = int'(next_rand() % MEM_DEPTH);
      issue_cmd(OP_WRITE, word_addr(idx), next_rand(), STRB_WIDTH'(i + 1));
      issue_cmd(OP_READ, word_addr(idx), '0, '0);
      wait_drain();
    end

    // Out of range, then the words an index wrap would hit
    issue_cmd(OP_WRITE, word_addr(MEM_DEPTH), next_rand(), '1);
    issue_cmd(OP_READ, word_addr(MEM_DEPTH), '0, '0);
    issue_cmd(OP_WRITE, 16'hfffc, next_rand(), '1);
    wait_drain();
    issue_cmd(OP_READ, 16'hfffc, '0, '0);
    issue_cmd(OP_READ, word_addr(0), '0, '0);
    issue_cmd(OP_READ, word_addr(MEM_DEPTH - 1), '0, '0);
    wait_drain();

    // Back-to-back random bursts, some beyond the memory
    for (int n = 0; n < N_BURSTS; n++) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        issue_rand(MEM_DEPTH + 8);
      end
      wait_drain();
    end

    // Overflow burst, stop at the first dropped strobe
    allow_drop = 1'b1;
    for (int i = 0; i < OVF_MAX && drop_cnt == 0; i++) begin
      issue_rand(MEM_DEPTH);
      if (drop_cnt != 0) begin
        assert (i >= FIFO_DEPTH) else begin
          $display("Strobe %0d dropped before the FIFO could be full", i);
          err_cnt++;
        end
      end
    end
    assert (drop_cnt == 1) else begin
      $display("No FIFO overflow seen during a long back-to-back burst");
      err_cnt++;
    end
    wait_drain();
    repeat (40) @(posedge aclk);
    assert (overflow) else begin
      $display("Overflow flag did not stay set");
      err_cnt++;
    end

    err_cnt += u_dut.u_sram.u_assert.fail_cnt;
    $display("Checks: %0d, errors: %0d, dropped commands: %0d", chk_cnt, err_cnt, drop_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* axil_sram_sys.f */
common/axil_pkg.sv
verilog/cmd_fifo.sv
axil_master/axil_master.sv
axil_sram/axil_sram_wrap.sv
verilog/axil_sram_sys.sv
testbench/axil_sram_assert.sv
testbench/tb_axil_sram_sys.sv

/* Bender.yml */
package:
  name: axil_sram_sys

sources:
  - common/axil_pkg.sv
  - verilog/cmd_fifo.sv
  - axil_master/axil_master.sv
  - axil_sram/axil_sram_wrap.sv
  - verilog/axil_sram_sys.sv
  - target: simulation
    files:
      - testbench/axil_sram_assert.sv
      - testbench/tb_axil_sram_sys.sv
